// File: rtl/rom_loader_defines.svh
// Pages are 16 KB and 9 bits wide, pages from 100 hex up form the high-ROM half of the 8 MB space
`ifndef ROM_LOADER_DEFINES_SVH
`define ROM_LOADER_DEFINES_SVH

////////////////////////////////////////
// Memory geometry
////////////////////////////////////////

`define ROM_PAGE_BITS    9      // 512 pages of 16 KB
`define ROM_ADDR_BITS    23     // Byte address inside one bank
`define DL_ADDR_BITS     25     // Host file address
`define PAGE_OFS_BITS    14     // Byte offset inside a page
`define ROM_MAP_PAGES    256    // High-ROM pages tracked in the map
`define MAIN_ROM_BLOCKS  8      // Two models of four blocks each

////////////////////////////////////////
// Fixed pages
////////////////////////////////////////

`define PAGE_OS          9'h000
`define PAGE_BASIC       9'h100
`define PAGE_AMSDOS      9'h107
`define PAGE_MF2         9'h0FF
`define PAGE_PLUS_CART   9'h1F0
`define PAGE_BAD_EXT     9'h1EE // Unused page, catches bad extensions

// clk_sys cycles per reference enable
`define REF_DIV          8

`endif

// File: rtl/rom_loader_pkg.sv
// Struct widths depend on the geometry macros, so the defines header is included before the package
`include "rom_loader_defines.svh"

package rom_loader_pkg;

	////////////////////////////////////////
	// Enums
	////////////////////////////////////////

	// Kind of file the host is streaming
	typedef enum logic [2:0] {
		DL_NONE,
		DL_MAIN_ROM,
		DL_EXPANSION,
		DL_GX4000,
		DL_PLUS_CART
	} download_kind_e;

	typedef enum logic [1:0] {
		SEQ_IDLE,   // No request pending
		SEQ_ARMED,  // Waiting for the next reference enable
		SEQ_WRITE,  // Write pulse on the memory port
		SEQ_REPEAT  // Gap before the bank 1 copy
	} seq_state_e;

	////////////////////////////////////////
	// Structs
	////////////////////////////////////////

	// Host download port
	typedef struct packed {
		logic                      download;
		logic [7:0]                index;
		logic [15:0]               file_ext;  // Two ASCII characters
		logic                      wr;
		logic [`DL_ADDR_BITS-1:0]  addr;
		logic [7:0]                data;
	} dl_port_t;

	// Accepted byte, valid while kind is not DL_NONE
	typedef struct packed {
		download_kind_e            kind;
		logic [7:0]                index;
		logic [`DL_ADDR_BITS-1:0]  addr;
		logic [7:0]                data;
	} dl_byte_t;

	typedef struct packed {
		logic [`ROM_ADDR_BITS-1:0] addr;
		logic [1:0]                bank;
		logic [7:0]                data;
		logic [`ROM_PAGE_BITS-2:0] map_page;
		logic                      map_valid;
		logic                      is_plus;
		logic                      dual_bank;
		logic                      valid;
	} mem_req_t;

	typedef struct packed {
		logic                      wr;
		logic [`ROM_ADDR_BITS-1:0] addr;
		logic [1:0]                bank;
		logic [7:0]                data;
	} mem_wr_t;

endpackage

// File: rtl/download_decoder.sv
// Only upper-case hex digits are decoded from the extension, and base_page is sampled at download start
`timescale 1ns/1ps
`include "rom_loader_defines.svh"

module download_decoder
	import rom_loader_pkg::*;
(
	input  logic                      clk_sys,
	input  logic                      reset,
	input  dl_port_t                  dl,
	input  logic                      busy,
	output dl_byte_t                  byte_out,
	output logic [`ROM_PAGE_BITS-1:0] base_page
);

	download_kind_e           kind;
	download_kind_e           kind_q;
	logic                     accept;
	logic                     old_download;
	logic [4:0]               ext_hi;
	logic [4:0]               ext_lo;
	logic [7:0]               index_q;
	logic [`DL_ADDR_BITS-1:0] addr_q;
	logic [7:0]               data_q;

	// {is_hex, value} of one ASCII character
	function automatic logic [4:0] hex_digit(input logic [7:0] c);
		logic [4:0] res;
		res = 5'h00;
		if (c >= "0" && c <= "9") res = {1'b1, c[3:0]};
		else if (c >= "A" && c <= "F") res = {1'b1, c[3:0] + 4'd9};
		return res;
	endfunction

	////////////////////////////////////////
	// Index classification
	////////////////////////////////////////

	always_comb begin
		kind = DL_NONE;
		if (dl.index[4:0] < 5'd4) begin
			if (dl.index == 8'd0) kind = DL_MAIN_ROM;
			else kind = DL_EXPANSION;  // Menu load or boot.eXX
		end else if (dl.index == 8'd5 || dl.index == 8'd6) begin
			kind = DL_GX4000;          // CPR and BIN
		end else if (dl.index == 8'd7) begin
			kind = DL_PLUS_CART;
		end
		// Index 4 is the tape, not handled here
	end

	assign accept = dl.download && dl.wr && (kind != DL_NONE) && !busy;
	assign ext_hi = hex_digit(dl.file_ext[15:8]);
	assign ext_lo = hex_digit(dl.file_ext[7:0]);

	////////////////////////////////////////
	// Control
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			kind_q       <= DL_NONE;
			old_download <= 1'b0;
			base_page    <= '0;
		end else begin
			kind_q       <= accept ? kind : DL_NONE;  // One-cycle strobe
			old_download <= dl.download;

			// Base page from the extension at download start
			if (dl.download && !old_download) begin
				if (dl.file_ext == "ZZ") base_page <= '0;
				else if (ext_hi[4] && ext_lo[4]) base_page <= {1'b0, ext_hi[3:0], ext_lo[3:0]};
				else base_page <= `PAGE_BAD_EXT;
			end
		end
	end

	// Byte payload
	always_ff @(posedge clk_sys) begin
		if (accept) begin
			index_q <= dl.index;
			addr_q  <= dl.addr;
			data_q  <= dl.data;
		end
	end

	assign byte_out = '{kind: kind_q, index: index_q, addr: addr_q, data: data_q};

endmodule

// File: rtl/boot_address_mapper.sv
// Expansion pages wrap inside their half of memory, and main ROM blocks past 7 are dropped silently
`timescale 1ns/1ps
`include "rom_loader_defines.svh"

module boot_address_mapper
	import rom_loader_pkg::*;
(
	input  logic                      clk_sys,
	input  logic                      reset,
	input  dl_byte_t                  byte_in,
	input  logic [`ROM_PAGE_BITS-1:0] base_page,
	output mem_req_t                  req
);

	localparam int MAP_BITS   = `ROM_PAGE_BITS - 1;
	localparam int BLOCK_BITS = `DL_ADDR_BITS - `PAGE_OFS_BITS;

	logic [BLOCK_BITS-1:0]     block;
	logic [MAP_BITS-1:0]       file_page;
	logic [`ROM_PAGE_BITS-1:0] page;
	logic [1:0]                bank;
	logic                      dual;
	logic                      hit;

	logic [`ROM_ADDR_BITS-1:0] addr_q;
	logic [1:0]                bank_q;
	logic [7:0]                data_q;
	logic                      plus_q;
	logic                      dual_q;
	logic                      valid_q;

	assign block     = byte_in.addr[`DL_ADDR_BITS-1:`PAGE_OFS_BITS];
	assign file_page = block[MAP_BITS-1:0];

	////////////////////////////////////////
	// Page and bank selection
	////////////////////////////////////////

	always_comb begin
		page = `PAGE_OS;
		bank = 2'd0;
		dual = 1'b0;
		hit  = 1'b0;
		case (byte_in.kind)
			DL_MAIN_ROM: begin
				hit  = (block < `MAIN_ROM_BLOCKS);
				bank = {1'b0, block[2]};  // 6128 in bank 0, 664 in bank 1
				case (block[1:0])
					2'd0: page = `PAGE_OS;
					2'd1: page = `PAGE_BASIC;
					2'd2: page = `PAGE_AMSDOS;
					default: page = `PAGE_MF2;
				endcase
			end
			DL_EXPANSION: begin
				hit  = 1'b1;
				page = {base_page[MAP_BITS], base_page[MAP_BITS-1:0] + file_page};
				bank = {2{&byte_in.index[7:6]}};
				// Both banks for a menu load or a boot name
				dual = (byte_in.index[7:6] == 2'b01 || |byte_in.index[5:0]) && (bank == 2'd0);
			end
			DL_GX4000: begin
				hit  = 1'b1;
				page = {1'b1, file_page};  // Second half at file address
			end
			DL_PLUS_CART: begin
				hit  = 1'b1;
				page = `PAGE_PLUS_CART;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (reset) valid_q <= 1'b0;
		else valid_q <= hit;
	end

	always_ff @(posedge clk_sys) begin
		if (byte_in.kind != DL_NONE) begin
			addr_q <= {page, byte_in.addr[`PAGE_OFS_BITS-1:0]};
			bank_q <= bank;
			data_q <= byte_in.data;
			plus_q <= (byte_in.kind == DL_PLUS_CART);
			dual_q <= dual;
		end
	end

	// Map bit follows the page's top bit
	assign req = '{
		addr:      addr_q,
		bank:      bank_q,
		data:      data_q,
		map_page:  addr_q[`ROM_ADDR_BITS-2 -: MAP_BITS],
		map_valid: addr_q[`ROM_ADDR_BITS-1],
		is_plus:   plus_q,
		dual_bank: dual_q,
		valid:     valid_q
	};

endmodule

// File: rtl/boot_write_sequencer.sv
// A new request is taken only in IDLE, so the host must hold wr low while busy is high
`timescale 1ns/1ps
`include "rom_loader_defines.svh"

module boot_write_sequencer
	import rom_loader_pkg::*;
(
	input  logic                      clk_sys,
	input  logic                      reset,
	input  mem_req_t                  req,
	output mem_wr_t                   mem_wr,
	output logic                      busy,
	output logic [`ROM_MAP_PAGES-1:0] rom_map,
	output logic                      plus_loaded
);

	localparam int DIV_BITS = $clog2(`REF_DIV);

	logic [DIV_BITS-1:0] div;
	logic                ce_ref;
	seq_state_e          state;
	mem_req_t            req_q;
	logic                wr_q;
	logic                repeat_bank;

	////////////////////////////////////////
	// Reference enable
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) div <= '0;
		else if (div == DIV_BITS'(`REF_DIV - 1)) div <= '0;
		else div <= div + 1'b1;
	end

	assign ce_ref = (div == '0);

	// Second pass into bank 1 still owed
	assign repeat_bank = req_q.dual_bank && (req_q.bank == 2'd0);

	////////////////////////////////////////
	// Write FSM
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state       <= SEQ_IDLE;
			wr_q        <= 1'b0;
			rom_map     <= '0;
			plus_loaded <= 1'b0;
		end else begin
			case (state)
				SEQ_IDLE: begin
					if (req.valid) state <= SEQ_ARMED;
				end
				SEQ_ARMED: begin
					if (ce_ref) begin
						state <= SEQ_WRITE;
						wr_q  <= 1'b1;
					end
				end
				SEQ_WRITE: begin
					if (ce_ref) begin
						wr_q <= 1'b0;  // Pulse spans one enable period
						if (repeat_bank) begin
							state <= SEQ_REPEAT;
						end else begin
							state <= SEQ_IDLE;
							if (req_q.map_valid) rom_map[req_q.map_page] <= 1'b1;
							if (req_q.is_plus) plus_loaded <= 1'b1;
						end
					end
				end
				SEQ_REPEAT: begin
					// Bank 1 copy after one idle period
					if (ce_ref) begin
						state <= SEQ_WRITE;
						wr_q  <= 1'b1;
					end
				end
				default: state <= SEQ_IDLE;
			endcase
		end
	end

	// Request hold register
	always_ff @(posedge clk_sys) begin
		if (state == SEQ_IDLE && req.valid) begin
			req_q <= req;
		end else if (state == SEQ_WRITE && ce_ref && repeat_bank) begin
			req_q.bank <= 2'd1;
		end
	end

	// Wait goes up with the request itself
	assign busy = req.valid || (state != SEQ_IDLE);

	assign mem_wr = '{wr: wr_q, addr: req_q.addr, bank: req_q.bank, data: req_q.data};

endmodule

// File: rtl/rom_loader.sv
// Host must keep wr low while wait_req is high, accepted bytes raise wait_req two cycles later
`timescale 1ns/1ps
`include "rom_loader_defines.svh"

module rom_loader
	import rom_loader_pkg::*;
(
	input  logic                      clk_sys,
	input  logic                      reset,
	input  dl_port_t                  dl,
	output logic                      wait_req,
	output mem_wr_t                   mem_wr,
	output logic [`ROM_MAP_PAGES-1:0] rom_map,
	output logic                      plus_loaded
);

	dl_byte_t                  dl_byte;
	mem_req_t                  mem_req;
	logic [`ROM_PAGE_BITS-1:0] base_page;

	////////////////////////////////////////
	// Input, mapping, output
	////////////////////////////////////////

	download_decoder download_decoder_i (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.dl        (dl),
		.busy      (wait_req),   // Back-pressure from the sequencer
		.byte_out  (dl_byte),
		.base_page (base_page)
	);

	boot_address_mapper boot_address_mapper_i (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.byte_in   (dl_byte),
		.base_page (base_page),
		.req       (mem_req)
	);

	boot_write_sequencer boot_write_sequencer_i (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.req         (mem_req),
		.mem_wr      (mem_wr),
		.busy        (wait_req),
		.rom_map     (rom_map),
		.plus_loaded (plus_loaded)
	);

endmodule

// File: tests/rom_loader_checker.sv
// Properties are off during reset, and the legal-byte decode follows the host index map of the loader
`timescale 1ns/1ps
`include "rom_loader_defines.svh"

module rom_loader_checker
	import rom_loader_pkg::*;
(
	input logic      clk_sys,
	input logic      reset,
	input dl_port_t  dl,
	input logic      wait_req,
	input mem_wr_t   mem_wr
);

	int   assert_fails;
	logic dl_write;
	logic main_block_ok;
	logic byte_legal;

	initial assert_fails = 0;

	assign dl_write      = dl.download && dl.wr && !wait_req;
	assign main_block_ok = dl.addr[`DL_ADDR_BITS-1:`PAGE_OFS_BITS] < `MAIN_ROM_BLOCKS;

	// Bytes that must reach the write sequencer
	always_comb begin
		byte_legal = 1'b0;
		if (dl.index[4:0] < 5'd4) begin
			byte_legal = (dl.index != 8'd0) || main_block_ok;
		end else if (dl.index inside {8'd5, 8'd6, 8'd7}) begin
			byte_legal = 1'b1;
		end
	end

	////////////////////////////////////////
	// Handshake
	////////////////////////////////////////

	wr_inside_wait: assert property (@(posedge clk_sys) disable iff (reset)
		mem_wr.wr |-> wait_req)
	else begin
		$error("mem_wr.wr is high while wait_req is low");
		assert_fails++;
	end

	wait_after_byte: assert property (@(posedge clk_sys) disable iff (reset)
		dl_write && byte_legal |-> ##1 !wait_req ##1 wait_req)
	else begin
		$error("wait_req did not rise two cycles after an accepted byte");
		assert_fails++;
	end

	wait_from_byte: assert property (@(posedge clk_sys) disable iff (reset)
		$rose(wait_req) |-> $past(dl_write && byte_legal, 2))
	else begin
		$error("wait_req rose without an accepted byte two cycles before");
		assert_fails++;
	end

	////////////////////////////////////////
	// Write pulse
	////////////////////////////////////////

	wr_pulse_len: assert property (@(posedge clk_sys) disable iff (reset)
		$rose(mem_wr.wr) |-> mem_wr.wr [*`REF_DIV] ##1 !mem_wr.wr)
	else begin
		$error("mem_wr.wr pulse does not last one reference period");
		assert_fails++;
	end

endmodule

bind rom_loader rom_loader_checker rom_loader_checker_i (
	.clk_sys  (clk_sys),
	.reset    (reset),
	.dl       (dl),
	.wait_req (wait_req),
	.mem_wr   (mem_wr)
);

// File: tests/rom_loader_tb.sv
// Each table entry is one byte in a download of its own, and the host never raises wr during wait_req
`timescale 1ns/1ps
`include "rom_loader_defines.svh"

module rom_loader_tb
	import rom_loader_pkg::*;
();

	localparam int MAX_CASES    = 32;
	localparam int RISE_TIMEOUT = 8;
	localparam int FALL_TIMEOUT = 64;
	localparam int DROP_WINDOW  = 16;

	// One host byte and the writes it must produce
	typedef struct packed {
		download_kind_e            kind;
		logic [7:0]                index;
		logic [15:0]               ext;
		logic [`DL_ADDR_BITS-1:0]  addr;
		logic [7:0]                data;
		logic [1:0]                n_wr;   // 2 means a second copy into bank 1
		logic [`ROM_PAGE_BITS-1:0] page;
		logic [1:0]                bank;   // Bank of the first write
	} case_t;

	logic                      clk_sys;
	logic                      reset;
	dl_port_t                  dl;
	logic                      wait_req;
	mem_wr_t                   mem_wr;
	logic [`ROM_MAP_PAGES-1:0] rom_map;
	logic                      plus_loaded;

	case_t  cases [0:MAX_CASES-1];
	string  case_names [0:MAX_CASES-1];
	int     n_cases;
	integer seed;

	// Captured write pulses
	logic [`ROM_ADDR_BITS-1:0] cap_addr [$];
	logic [1:0]                cap_bank [$];
	logic [7:0]                cap_data [$];
	logic                      wr_prev;

	logic [`ROM_MAP_PAGES-1:0] exp_map;
	logic                      exp_plus;
	int                        errors;
	int                        case_errors;
	int                        n_run;
	int                        n_failed;
	int                        checker_errors;
	logic                      timed_out;

	rom_loader rom_loader_i (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.dl          (dl),
		.wait_req    (wait_req),
		.mem_wr      (mem_wr),
		.rom_map     (rom_map),
		.plus_loaded (plus_loaded)
	);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	// Record each write at its first cycle
	always @(negedge clk_sys) begin
		if (reset) begin
			wr_prev <= 1'b0;
		end else begin
			if (mem_wr.wr && !wr_prev) begin
				cap_addr.push_back(mem_wr.addr);
				cap_bank.push_back(mem_wr.bank);
				cap_data.push_back(mem_wr.data);
			end
			wr_prev <= mem_wr.wr;
		end
	end

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////

	// Memory address of a byte at a page offset
	function automatic logic [`ROM_ADDR_BITS-1:0] rom_addr(
		input logic [`ROM_PAGE_BITS-1:0] page,
		input logic [`PAGE_OFS_BITS-1:0] ofs
	);
		return {page, ofs};
	endfunction

	task automatic add_case(
		input string                     name,
		input download_kind_e            kind,
		input logic [7:0]                index,
		input logic [15:0]               ext,
		input logic [10:0]               block,
		input logic [`PAGE_OFS_BITS-1:0] ofs,
		input int                        n_wr,
		input logic [`ROM_PAGE_BITS-1:0] page,
		input logic [1:0]                bank
	);
		case_t       c;
		logic [31:0] rnd;
		rnd     = $random(seed);
		c.kind  = kind;
		c.index = index;
		c.ext   = ext;
		c.addr  = {block, ofs};
		c.data  = rnd[7:0];
		c.n_wr  = 2'(n_wr);
		c.page  = page;
		c.bank  = bank;
		cases[n_cases]      = c;
		case_names[n_cases] = name;
		n_cases++;
	endtask

	task automatic check_value(input string name, input logic [255:0] got,
		input logic [255:0] exp);
		assert (got === exp) else begin
			$display("ERROR %0d ns: %s is %0h, expected %0h", $time, name, got, exp);
			errors++;
			case_errors++;
		end
	endtask

	task automatic build_table();
		// Ignored index
		add_case("tape index 4", DL_NONE, 8'h04, "CD", 11'd0, 14'h0100, 0, 9'h000, 2'd0);
		// Main ROM set, 6128 in bank 0 and 664 in bank 1
		add_case("main os 6128", DL_MAIN_ROM, 8'h00, "RO", 11'd0, 14'h0005, 1, `PAGE_OS, 2'd0);
		add_case("main basic 6128", DL_MAIN_ROM, 8'h00, "RO", 11'd1, 14'h3FFF, 1, `PAGE_BASIC, 2'd0);
		add_case("main amsdos 6128", DL_MAIN_ROM, 8'h00, "RO", 11'd2, 14'h1234, 1, `PAGE_AMSDOS, 2'd0);
		add_case("main mf2 6128", DL_MAIN_ROM, 8'h00, "RO", 11'd3, 14'h0800, 1, `PAGE_MF2, 2'd0);
		add_case("main os 664", DL_MAIN_ROM, 8'h00, "RO", 11'd4, 14'h0001, 1, `PAGE_OS, 2'd1);
		add_case("main basic 664", DL_MAIN_ROM, 8'h00, "RO", 11'd5, 14'h2222, 1, `PAGE_BASIC, 2'd1);
		add_case("main amsdos 664", DL_MAIN_ROM, 8'h00, "RO", 11'd6, 14'h0C00, 1, `PAGE_AMSDOS, 2'd1);
		add_case("main mf2 664", DL_MAIN_ROM, 8'h00, "RO", 11'd7, 14'h3000, 1, `PAGE_MF2, 2'd1);
		add_case("main block 9", DL_MAIN_ROM, 8'h00, "RO", 11'd9, 14'h0040, 0, 9'h000, 2'd0);
		// Expansion ROMs
		add_case("exp 2A block 0", DL_EXPANSION, 8'h01, "2A", 11'd0, 14'h0010, 2, 9'h02A, 2'd0);
		add_case("exp 2A block 3", DL_EXPANSION, 8'h01, "2A", 11'd3, 14'h2001, 2, 9'h02D, 2'd0);
		add_case("exp boot 15", DL_EXPANSION, 8'h40, "15", 11'd2, 14'h0333, 2, 9'h017, 2'd0);
		add_case("exp C0 ZZ", DL_EXPANSION, 8'hC0, "ZZ", 11'd0, 14'h0777, 1, 9'h000, 2'd3);
		add_case("exp bad ext", DL_EXPANSION, 8'h02, "Q7", 11'd0, 14'h0001, 2, `PAGE_BAD_EXT, 2'd0);
		add_case("exp C0 bad ext", DL_EXPANSION, 8'hC0, "G5", 11'd0, 14'h1000, 1, `PAGE_BAD_EXT, 2'd3);
		// Cartridges
		add_case("gx4000 cpr", DL_GX4000, 8'h05, "PR", 11'h012, 14'h0ABC, 1, 9'h112, 2'd0);
		add_case("gx4000 bin", DL_GX4000, 8'h06, "IN", 11'h03C, 14'h3210, 1, 9'h13C, 2'd0);
		add_case("plus cart", DL_PLUS_CART, 8'h07, "PR", 11'd0, 14'h0042, 1, `PAGE_PLUS_CART, 2'd0);
	endtask

	////////////////////////////////////////
	// One table entry
	////////////////////////////////////////

	task automatic run_case(input int i);
		case_t c;
		int    cycles;
		logic  seen;
		c           = cases[i];
		case_errors = 0;
		cap_addr.delete();
		cap_bank.delete();
		cap_data.delete();

		@(posedge clk_sys);
		dl.download <= 1'b1;  // Base page is taken here
		dl.index    <= c.index;
		dl.file_ext <= c.ext;
		dl.addr     <= c.addr;
		dl.data     <= c.data;
		dl.wr       <= 1'b0;
		@(posedge clk_sys);
		dl.wr <= 1'b1;
		@(posedge clk_sys);
		dl.wr <= 1'b0;
		@(negedge clk_sys);

		if (c.n_wr == 0) begin
			seen   = 1'b0;
			cycles = 0;
			while (cycles < DROP_WINDOW) begin
				if (wait_req) seen = 1'b1;
				@(negedge clk_sys);
				cycles++;
			end
			assert (!seen) else begin
				$display("%s: wait_req went high for a byte that must be dropped", case_names[i]);
				errors++;
				case_errors++;
			end
		end else begin
			cycles = 0;
			while (!wait_req && cycles < RISE_TIMEOUT) begin
				@(negedge clk_sys);
				cycles++;
			end
			if (!wait_req) begin
				$display("%s: timeout, wait_req did not rise after the byte", case_names[i]);
				errors++;
				timed_out = 1'b1;
				return;
			end
			cycles = 0;
			while (wait_req && cycles < FALL_TIMEOUT) begin
				@(negedge clk_sys);
				cycles++;
			end
			if (wait_req) begin
				$display("%s: timeout, wait_req still high after %0d cycles", case_names[i],
					FALL_TIMEOUT);
				errors++;
				timed_out = 1'b1;
				return;
			end
		end

		check_value("mem_wr.wr pulse count", cap_addr.size(), c.n_wr);
		for (int k = 0; k < cap_addr.size() && k < c.n_wr; k++) begin
			check_value("mem_wr.addr", cap_addr[k], rom_addr(c.page, c.addr[`PAGE_OFS_BITS-1:0]));
			check_value("mem_wr.bank", cap_bank[k], (k == 0) ? c.bank : 2'd1);
			check_value("mem_wr.data", cap_data[k], c.data);
		end

		// High half pages are tracked in the map
		if (c.n_wr != 0 && c.page[`ROM_PAGE_BITS-1]) exp_map[c.page[7:0]] = 1'b1;
		if (c.n_wr != 0 && c.kind == DL_PLUS_CART) exp_plus = 1'b1;
		check_value("rom_map", rom_map, exp_map);
		check_value("plus_loaded", plus_loaded, exp_plus);

		@(posedge clk_sys);
		dl.download <= 1'b0;
		@(posedge clk_sys);
		$display("%s: %s", case_names[i], (case_errors == 0) ? "ok" : "FAILED");
		n_run++;
		if (case_errors != 0) n_failed++;
	endtask

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////

	initial begin
		reset     = 1'b1;
		dl        = '0;
		seed      = 32'hd240d16f;
		n_cases   = 0;
		errors    = 0;
		n_run     = 0;
		n_failed  = 0;
		exp_map   = '0;
		exp_plus  = 1'b0;
		timed_out = 1'b0;
		build_table();

		repeat (4) @(posedge clk_sys);
		reset <= 1'b0;
		@(negedge clk_sys);

		// Outputs straight after reset
		case_errors = 0;
		check_value("wait_req", wait_req, 1'b0);
		check_value("mem_wr.wr", mem_wr.wr, 1'b0);
		check_value("rom_map", rom_map, '0);
		check_value("plus_loaded", plus_loaded, 1'b0);
		$display("reset state: %s", (case_errors == 0) ? "ok" : "FAILED");
		n_run++;
		if (case_errors != 0) n_failed++;

		for (int i = 0; i < n_cases && !timed_out; i++) begin
			run_case(i);
		end

		checker_errors = rom_loader_i.rom_loader_checker_i.assert_fails;
		$display("%0d tests run, %0d with errors, %0d check errors, %0d assertion errors",
			n_run, n_failed, errors, checker_errors);
		if (errors == 0 && checker_errors == 0 && !timed_out) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

// File: compile.f
+incdir+rtl
rtl/rom_loader_pkg.sv
rtl/download_decoder.sv
rtl/boot_address_mapper.sv
rtl/boot_write_sequencer.sv
rtl/rom_loader.sv
tests/rom_loader_checker.sv
tests/rom_loader_tb.sv

// File: Bender.yml
package:
  name: rom_loader

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/rom_loader_pkg.sv
      - rtl/download_decoder.sv
      - rtl/boot_address_mapper.sv
      - rtl/boot_write_sequencer.sv
      - rtl/rom_loader.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tests/rom_loader_checker.sv
      - tests/rom_loader_tb.sv
